//--- source/prbs_fec_pkg.sv
package prbs_fec_pkg;

    // FEC symbol geometry
    localparam int SYM_BITS   = 10;
    localparam int CW_SYMBOLS = 54;

    // most symbol errors a codeword can carry and still decode
    localparam int T_CORRECT = 15;

    // interleaved codewords, dealt round-robin per symbol
    localparam int LANES = 4;

    // PRBS63 shift register length
    localparam int PRBS_LEN = 63;

    // seed is 64 bits on the port, only the low PRBS_LEN bits load
    typedef logic [63:0] seed_t;

    typedef logic [PRBS_LEN-1:0] lfsr_t;

    // lane index and per-symbol / per-codeword counters
    typedef logic [1:0] lane_t;
    typedef logic [3:0] sym_bit_t;
    typedef logic [5:0] sym_cnt_t;

    // bit errors inside one codeword, up to 540
    typedef logic [9:0] cw_err_t;

    // running totals
    typedef logic [63:0] stat_t;

endpackage

//--- source/prbs63_gen.sv
module prbs63_gen (
    input  logic                clk,
    input  logic                rstn,
    input  logic                en,
    input  logic                restart,
    input  prbs_fec_pkg::seed_t seed,
    output logic                tx_data,
    output logic                tx_valid
);

    prbs_fec_pkg::lfsr_t sr;
    logic                fb;

    // taps at bits 62 and 61
    assign fb = sr[62] ^ sr[61];

    // shift register and valid level
    always_ff @(posedge clk) begin
        if (!rstn || restart) begin
            sr       <= seed[prbs_fec_pkg::PRBS_LEN-1:0];
            tx_valid <= 1'b0;
        end else if (en) begin
            sr       <= {sr[prbs_fec_pkg::PRBS_LEN-2:0], fb};
            tx_valid <= 1'b1;
        end else begin
            tx_valid <= 1'b0;
        end
    end

    // data bit only moves on an enabled cycle
    always_ff @(posedge clk) begin
        if (en) begin
            tx_data <= fb;
        end
    end

endmodule

//--- source/prbs_err_decode.sv
module prbs_err_decode (
    input  logic                clk,
    input  logic                rstn,
    input  logic                restart,
    input  prbs_fec_pkg::seed_t seed,
    input  logic                rx_data,
    input  logic                rx_valid,
    output logic                bit_valid,
    output logic                bit_err
);

    // local copy of the transmit sequence
    prbs_fec_pkg::lfsr_t ref_sr;
    logic                expected;

    assign expected = ref_sr[62] ^ ref_sr[61];

    // reference only advances on received bits, so gaps keep alignment
    always_ff @(posedge clk) begin
        if (!rstn || restart) begin
            ref_sr    <= seed[prbs_fec_pkg::PRBS_LEN-1:0];
            bit_valid <= 1'b0;
        end else begin
            bit_valid <= rx_valid;
            if (rx_valid) begin
                ref_sr <= {ref_sr[prbs_fec_pkg::PRBS_LEN-2:0], expected};
            end
        end
    end

    // mismatch flag, meaningful only with bit_valid
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            bit_err <= rx_data ^ expected;
        end
    end

endmodule

//--- source/fec_lane_tracker.sv
module fec_lane_tracker (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  restart,
    input  logic                  bit_valid,
    input  logic                  bit_err,
    output logic                  cw_done,
    output logic                  cw_fail,
    output prbs_fec_pkg::cw_err_t cw_bit_errs
);

    localparam int LANES = prbs_fec_pkg::LANES;

    // lane pointer and position in the current symbol
    prbs_fec_pkg::lane_t    lane;
    prbs_fec_pkg::sym_bit_t bit_idx;

    // per-lane codeword state
    prbs_fec_pkg::sym_cnt_t sym_cnt  [LANES];
    prbs_fec_pkg::sym_cnt_t err_syms [LANES];
    prbs_fec_pkg::cw_err_t  bit_errs [LANES];
    logic                   sym_err  [LANES];

    // current lane values with this bit folded in
    logic                   cur_sym_err;
    prbs_fec_pkg::cw_err_t  cur_bit_errs;
    prbs_fec_pkg::sym_cnt_t cur_err_syms;
    logic                   sym_end;
    logic                   cw_end;
    prbs_fec_pkg::lane_t    next_lane;

    always_comb begin
        cur_sym_err  = sym_err[lane] | bit_err;
        cur_bit_errs = bit_errs[lane] + prbs_fec_pkg::cw_err_t'(bit_err);
        cur_err_syms = err_syms[lane] + prbs_fec_pkg::sym_cnt_t'(cur_sym_err);
        sym_end      = (bit_idx == prbs_fec_pkg::sym_bit_t'(prbs_fec_pkg::SYM_BITS - 1));
        cw_end       = sym_end &&
                       (sym_cnt[lane] == prbs_fec_pkg::sym_cnt_t'(prbs_fec_pkg::CW_SYMBOLS - 1));
        if (lane == prbs_fec_pkg::lane_t'(LANES - 1)) begin
            next_lane = '0;
        end else begin
            next_lane = lane + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || restart) begin
            lane    <= '0;
            bit_idx <= '0;
            cw_done <= 1'b0;
            cw_fail <= 1'b0;
            for (int i = 0; i < LANES; i++) begin
                sym_cnt[i]  <= '0;
                err_syms[i] <= '0;
                bit_errs[i] <= '0;
                sym_err[i]  <= 1'b0;
            end
        end else begin
            cw_done <= 1'b0;
            cw_fail <= 1'b0;
            if (bit_valid) begin
                if (!sym_end) begin
                    bit_idx        <= bit_idx + 1'b1;
                    sym_err[lane]  <= cur_sym_err;
                    bit_errs[lane] <= cur_bit_errs;
                end else begin
                    // symbol closes, next symbol belongs to the next lane
                    bit_idx       <= '0;
                    lane          <= next_lane;
                    sym_err[lane] <= 1'b0;
                    if (cw_end) begin
                        // judge against T and start a fresh codeword on this lane
                        cw_done        <= 1'b1;
                        cw_fail        <= (cur_err_syms > prbs_fec_pkg::T_CORRECT);
                        sym_cnt[lane]  <= '0;
                        err_syms[lane] <= '0;
                        bit_errs[lane] <= '0;
                    end else begin
                        sym_cnt[lane]  <= sym_cnt[lane] + 1'b1;
                        err_syms[lane] <= cur_err_syms;
                        bit_errs[lane] <= cur_bit_errs;
                    end
                end
            end
        end
    end

    // payload, qualified by cw_done
    always_ff @(posedge clk) begin
        if (bit_valid && cw_end) begin
            cw_bit_errs <= cur_bit_errs;
        end
    end

endmodule

//--- source/ber_stats.sv
module ber_stats (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  bit_valid,
    input  logic                  bit_err,
    input  logic                  cw_done,
    input  logic                  cw_fail,
    input  prbs_fec_pkg::cw_err_t cw_bit_errs,
    output prbs_fec_pkg::stat_t   total_bits,
    output prbs_fec_pkg::stat_t   total_errs_pre,
    output prbs_fec_pkg::stat_t   total_errs_post,
    output prbs_fec_pkg::stat_t   total_frames,
    output prbs_fec_pkg::stat_t   total_frame_errs
);

    // raw bit totals, one per received bit
    always_ff @(posedge clk) begin
        if (!rstn) begin
            total_bits     <= '0;
            total_errs_pre <= '0;
        end else if (bit_valid) begin
            total_bits     <= total_bits + 1'b1;
            total_errs_pre <= total_errs_pre + prbs_fec_pkg::stat_t'(bit_err);
        end
    end

    // codeword totals
    always_ff @(posedge clk) begin
        if (!rstn) begin
            total_frames     <= '0;
            total_frame_errs <= '0;
            total_errs_post  <= '0;
        end else if (cw_done) begin
            total_frames <= total_frames + 1'b1;
            if (cw_fail) begin
                // uncorrectable, every bit error of the codeword survives
                total_frame_errs <= total_frame_errs + 1'b1;
                total_errs_post  <= total_errs_post + prbs_fec_pkg::stat_t'(cw_bit_errs);
            end
        end
    end

endmodule

//--- source/prbs_fec_tester.sv
module prbs_fec_tester (
    input  logic                clk,
    input  logic                rstn,
    input  logic                en,
    input  prbs_fec_pkg::seed_t seed,
    input  logic                restart,
    input  logic                rx_data,
    input  logic                rx_valid,
    output logic                tx_data,
    output logic                tx_valid,
    output prbs_fec_pkg::stat_t total_bits,
    output prbs_fec_pkg::stat_t total_errs_pre,
    output prbs_fec_pkg::stat_t total_errs_post,
    output prbs_fec_pkg::stat_t total_frames,
    output prbs_fec_pkg::stat_t total_frame_errs
);

    // decode to tracker and stats
    logic                  bit_valid;
    logic                  bit_err;

    // tracker to stats
    logic                  cw_done;
    logic                  cw_fail;
    prbs_fec_pkg::cw_err_t cw_bit_errs;

    prbs63_gen i_gen (
        .clk      (clk),
        .rstn     (rstn),
        .en       (en),
        .restart  (restart),
        .seed     (seed),
        .tx_data  (tx_data),
        .tx_valid (tx_valid)
    );

    prbs_err_decode i_decode (
        .clk       (clk),
        .rstn      (rstn),
        .restart   (restart),
        .seed      (seed),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .bit_valid (bit_valid),
        .bit_err   (bit_err)
    );

    fec_lane_tracker i_tracker (
        .clk         (clk),
        .rstn        (rstn),
        .restart     (restart),
        .bit_valid   (bit_valid),
        .bit_err     (bit_err),
        .cw_done     (cw_done),
        .cw_fail     (cw_fail),
        .cw_bit_errs (cw_bit_errs)
    );

    // totals survive restart, only rstn clears them
    ber_stats i_stats (
        .clk              (clk),
        .rstn             (rstn),
        .bit_valid        (bit_valid),
        .bit_err          (bit_err),
        .cw_done          (cw_done),
        .cw_fail          (cw_fail),
        .cw_bit_errs      (cw_bit_errs),
        .total_bits       (total_bits),
        .total_errs_pre   (total_errs_pre),
        .total_errs_post  (total_errs_post),
        .total_frames     (total_frames),
        .total_frame_errs (total_frame_errs)
    );

endmodule

//--- sim/prbs_fec_asserts.sv
module prbs_fec_asserts (
    input logic clk,
    input logic rstn,
    input logic restart,
    input logic bit_valid,
    input logic cw_done,
    input logic cw_fail
);
    timeunit 1ns;
    timeprecision 100ps;

    // failures seen so far, read by the testbench at the end
    int fail_cnt = 0;

    // a fail verdict only comes with its codeword
    fail_with_done: assert property (
        @(posedge clk) disable iff (!rstn) cw_fail |-> cw_done
    ) else begin
        fail_cnt++;
        $error("cw_fail high without cw_done");
    end

    // codeword end is always triggered by a received bit
    done_after_bit: assert property (
        @(posedge clk) disable iff (!rstn) cw_done |-> $past(bit_valid)
    ) else begin
        fail_cnt++;
        $error("cw_done without bit_valid in the previous cycle");
    end

    // restart flushes the decode stage
    quiet_after_restart: assert property (
        @(posedge clk) disable iff (!rstn) restart |=> !bit_valid
    ) else begin
        fail_cnt++;
        $error("bit_valid in the cycle after restart");
    end

endmodule

bind fec_lane_tracker prbs_fec_asserts i_asserts (
    .clk       (clk),
    .rstn      (rstn),
    .restart   (restart),
    .bit_valid (bit_valid),
    .cw_done   (cw_done),
    .cw_fail   (cw_fail)
);

//--- sim/tb_prbs_fec.sv
module tb_prbs_fec;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NROWS       = 6;
    localparam int BITS_PER_CW = prbs_fec_pkg::SYM_BITS * prbs_fec_pkg::CW_SYMBOLS;

    typedef struct packed {
        prbs_fec_pkg::seed_t seed;
        int                  rounds;
        int                  err_syms;
        int                  err_bits;
        logic                en_gap;
    } row_t;

    logic                clk;
    logic                rstn;
    logic                en;
    logic                restart;
    prbs_fec_pkg::seed_t seed;
    logic                rx_data;
    logic                rx_valid;
    logic                tx_data;
    logic                tx_valid;
    prbs_fec_pkg::stat_t total_bits;
    prbs_fec_pkg::stat_t total_errs_pre;
    prbs_fec_pkg::stat_t total_errs_post;
    prbs_fec_pkg::stat_t total_frames;
    prbs_fec_pkg::stat_t total_frame_errs;

    row_t                rows [NROWS];
    int                  seed_var;
    int                  bit_pos;
    int                  cur_err_syms;
    int                  cur_err_bits;
    int                  cycle_cnt;
    int                  max_cycles;

    // transmit sequence model built from the taps at bits 62 and 61
    prbs_fec_pkg::lfsr_t model_sr;
    logic                model_bit;

    // running expectation that only rstn clears
    prbs_fec_pkg::stat_t exp_bits;
    prbs_fec_pkg::stat_t exp_pre;
    prbs_fec_pkg::stat_t exp_post;
    prbs_fec_pkg::stat_t exp_frames;
    prbs_fec_pkg::stat_t exp_frame_errs;

    prbs_fec_tester i_dut (
        .clk              (clk),
        .rstn             (rstn),
        .en               (en),
        .seed             (seed),
        .restart          (restart),
        .rx_data          (rx_data),
        .rx_valid         (rx_valid),
        .tx_data          (tx_data),
        .tx_valid         (tx_valid),
        .total_bits       (total_bits),
        .total_errs_pre   (total_errs_pre),
        .total_errs_post  (total_errs_post),
        .total_frames     (total_frames),
        .total_frame_errs (total_frame_errs)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // flip decision from the symbol-in-lane index and bit-in-symbol of a stream position
    function automatic logic flip_bit(input int pos, input int n_syms, input int n_bits);
        int stream_sym;
        int sym_in_lane;
        int bit_in_sym;
        stream_sym  = pos / prbs_fec_pkg::SYM_BITS;
        bit_in_sym  = pos % prbs_fec_pkg::SYM_BITS;
        sym_in_lane = (stream_sym / prbs_fec_pkg::LANES) % prbs_fec_pkg::CW_SYMBOLS;
        return (sym_in_lane < n_syms) && (bit_in_sym < n_bits);
    endfunction

    // loopback with flips where an X on the tx side reads as 0
    always_comb begin
        rx_valid = (tx_valid === 1'b1);
        rx_data  = (tx_data === 1'b1) ^ flip_bit(bit_pos, cur_err_syms, cur_err_bits);
    end

    // position of the bit on the wire since the last reset or restart
    always @(posedge clk) begin
        if (!rstn || restart) begin
            bit_pos <= 0;
        end else if (tx_valid === 1'b1) begin
            bit_pos <= bit_pos + 1;
        end
    end

    // each valid transmit bit against the PRBS63 rule
    always @(posedge clk) begin
        if (!rstn || restart) begin
            model_sr <= seed[prbs_fec_pkg::PRBS_LEN-1:0];
        end else if (tx_valid === 1'b1) begin
            model_bit = model_sr[62] ^ model_sr[61];
            check_bit("tx_data", tx_data, model_bit);
            model_sr <= {model_sr[prbs_fec_pkg::PRBS_LEN-2:0], model_bit};
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: the run did not complete within %0d cycles", max_cycles);
            $display("TEST FAIL");
            $fatal(1, "simulation timeout");
        end
    end

    function automatic prbs_fec_pkg::seed_t draw_seed();
        prbs_fec_pkg::seed_t s;
        s = {$random(seed_var), $random(seed_var)};
        // an all-zero register would lock up
        return s | 64'd1;
    endfunction

    function automatic int row_cycles(input int idx);
        int nbits;
        nbits = BITS_PER_CW * prbs_fec_pkg::LANES * rows[idx].rounds;
        return 8 + nbits + (rows[idx].en_gap ? nbits / 6 + 1 : 0);
    endfunction

    task automatic check_stat(input string name, input prbs_fec_pkg::stat_t got,
                              input prbs_fec_pkg::stat_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic run_row(input int idx);
        int  nbits;
        int  sent;
        int  cyc;
        int  d_pre;
        int  d_frames;
        logic fails;
        nbits        = BITS_PER_CW * prbs_fec_pkg::LANES * rows[idx].rounds;
        seed         = rows[idx].seed;
        cur_err_syms = rows[idx].err_syms;
        cur_err_bits = rows[idx].err_bits;
        // a stray bit lands in the restart cycle and gets dropped
        en = 1'b1;
        @(posedge clk);
        #1;
        en      = 1'b0;
        restart = 1'b1;
        @(posedge clk);
        #1;
        restart = 1'b0;
        sent    = 0;
        cyc     = 0;
        while (sent < nbits) begin
            if (rows[idx].en_gap && (cyc % 7 == 6)) begin
                en = 1'b0;
            end else begin
                en   = 1'b1;
                sent = sent + 1;
            end
            cyc = cyc + 1;
            @(posedge clk);
            #1;
        end
        en = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        // deltas from the codeword geometry
        d_frames = prbs_fec_pkg::LANES * rows[idx].rounds;
        d_pre    = rows[idx].err_syms * rows[idx].err_bits * d_frames;
        fails    = (rows[idx].err_syms > prbs_fec_pkg::T_CORRECT);
        exp_bits   = exp_bits + prbs_fec_pkg::stat_t'(nbits);
        exp_pre    = exp_pre + prbs_fec_pkg::stat_t'(d_pre);
        exp_frames = exp_frames + prbs_fec_pkg::stat_t'(d_frames);
        if (fails) begin
            exp_frame_errs = exp_frame_errs + prbs_fec_pkg::stat_t'(d_frames);
            exp_post       = exp_post + prbs_fec_pkg::stat_t'(d_pre);
        end
        check_stat("total_bits", total_bits, exp_bits);
        check_stat("total_errs_pre", total_errs_pre, exp_pre);
        check_stat("total_errs_post", total_errs_post, exp_post);
        check_stat("total_frames", total_frames, exp_frames);
        check_stat("total_frame_errs", total_frame_errs, exp_frame_errs);
        check_bit("tx_valid when idle", tx_valid, 1'b0);
    endtask

    initial begin
        rstn           = 1'b0;
        en             = 1'b0;
        restart        = 1'b0;
        seed           = 64'd1;
        bit_pos        = 0;
        cur_err_syms   = 0;
        cur_err_bits   = 0;
        cycle_cnt      = 0;
        seed_var       = 32'h88dd_b4a2;
        exp_bits       = '0;
        exp_pre        = '0;
        exp_post       = '0;
        exp_frames     = '0;
        exp_frame_errs = '0;

        // seed, rounds, error symbols, bits per symbol, en gaps
        rows[0] = '{seed: 64'd1, rounds: 1, err_syms: 0, err_bits: 0, en_gap: 1'b0};
        rows[1] = '{seed: draw_seed(), rounds: 2, err_syms: 0, err_bits: 0, en_gap: 1'b0};
        rows[2] = '{seed: 64'h0123_4567_89ab_cdef, rounds: 1, err_syms: 15, err_bits: 1,
                    en_gap: 1'b0};
        rows[3] = '{seed: 64'h7fff_0000_ffff_1234, rounds: 1, err_syms: 16, err_bits: 1,
                    en_gap: 1'b0};
        rows[4] = '{seed: draw_seed(), rounds: 2, err_syms: 10, err_bits: 3, en_gap: 1'b0};
        rows[5] = '{seed: draw_seed(), rounds: 2, err_syms: 10, err_bits: 3, en_gap: 1'b1};

        max_cycles = 4 + 200;
        for (int i = 0; i < NROWS; i++) begin
            max_cycles = max_cycles + row_cycles(i);
        end

        repeat (4) @(posedge clk);
        #1;
        check_bit("tx_valid after reset", tx_valid, 1'b0);
        rstn = 1'b1;

        for (int i = 0; i < NROWS; i++) begin
            run_row(i);
        end

        if (i_dut.i_tracker.i_asserts.fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("%0d assertion failures during the run", i_dut.i_tracker.i_asserts.fail_cnt);
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- prbs_fec.f
source/prbs_fec_pkg.sv
source/prbs63_gen.sv
source/prbs_err_decode.sv
source/fec_lane_tracker.sv
source/ber_stats.sv
source/prbs_fec_tester.sv
sim/prbs_fec_asserts.sv
sim/tb_prbs_fec.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the PRBS63 / FEC tester testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_prbs_fec -f prbs_fec.f -o tb_prbs_fec \
    || { echo "build failed"; exit 1; }

out="$(./obj_dir/tb_prbs_fec 2>&1)"
echo "$out"
echo "$out" | grep -qx "TEST PASS" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
